// ==== hw/csr_pkg.sv ====
/*
 * csr package
 * CSR addresses, field masks, reset values and the channel types of the CSR unit
 */
`default_nettype none

package csr_pkg;

	localparam int XLEN = 64;

	// machine mode CSR addresses
	localparam logic [11:0] CSR_MSTATUS  = 12'h300;
	localparam logic [11:0] CSR_MISA     = 12'h301;
	localparam logic [11:0] CSR_MIE      = 12'h304;
	localparam logic [11:0] CSR_MTVEC    = 12'h305;
	localparam logic [11:0] CSR_MSCRATCH = 12'h340;
	localparam logic [11:0] CSR_MEPC     = 12'h341;
	localparam logic [11:0] CSR_MCAUSE   = 12'h342;
	localparam logic [11:0] CSR_MTVAL    = 12'h343;
	localparam logic [11:0] CSR_MCYCLE   = 12'hb00;
	localparam logic [11:0] CSR_MHARTID  = 12'hf14;

	// writable bits only
	// mstatus keeps MPIE and MIE
	localparam logic [XLEN-1:0] MSTATUS_WMASK = 64'h0000_0000_0000_0088;
	// mie keeps MEIE, MTIE and MSIE
	localparam logic [XLEN-1:0] MIE_WMASK     = 64'h0000_0000_0000_0888;

	// MXL = 2 for 64 bit, extension I
	localparam logic [XLEN-1:0] ISA_RV64I     = 64'h8000_0000_0000_0100;

	// MIE set and MPIE clear out of reset
	localparam logic [XLEN-1:0] MSTATUS_RST   = 64'h0000_0000_0000_0008;
	localparam logic [XLEN-1:0] MIE_RST       = 64'h0000_0000_0000_0888;

	// same encoding as funct3 of the csr instructions
	typedef enum logic [2:0] {
		OP_RW  = 3'd1,
		OP_RS  = 3'd2,
		OP_RC  = 3'd3,
		OP_RWI = 3'd5,
		OP_RSI = 3'd6,
		OP_RCI = 3'd7
	} csr_op_e;

	typedef enum logic {
		TRAP_EXC  = 1'b0,
		TRAP_MRET = 1'b1
	} trap_kind_e;

	typedef struct packed {
		csr_op_e         op;
		logic [11:0]     addr;
		logic [XLEN-1:0] operand;
		logic [4:0]      zimm;
	} csr_req_t;

	typedef struct packed {
		logic [XLEN-1:0] rdata;
		logic            illegal;
	} csr_rsp_t;

	typedef struct packed {
		trap_kind_e      kind;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] cause;
		logic [XLEN-1:0] tval;
	} trap_req_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
	} redirect_t;

	typedef struct packed {
		logic            we;
		logic [11:0]     addr;
		logic [XLEN-1:0] data;
	} csr_wr_t;

	// mstatus fields, WPRI bits read as zero
	typedef struct packed {
		logic [55:0] wpri_hi;
		logic        mpie;
		logic [2:0]  wpri_mid;
		logic        mie;
		logic [2:0]  wpri_lo;
	} mstatus_t;

	typedef union packed {
		logic [XLEN-1:0] raw;
		mstatus_t        f;
	} mstatus_u;

endpackage

`default_nettype wire

// ==== hw/csr_alu.sv ====
/*
 * csr alu
 * new CSR value and write decision for csrrw/csrrs/csrrc and the immediate forms
 */
`timescale 1ns/1ps
`default_nettype none

module csr_alu
	import csr_pkg::*;
(
	input  csr_op_e         op_i,
	input  logic [XLEN-1:0] old_i,
	input  logic [XLEN-1:0] operand_i,
	input  logic [4:0]      zimm_i,
	output logic [XLEN-1:0] new_o,
	output logic            we_o
);

	logic [XLEN-1:0] src;

	always_comb begin
		// immediate forms take zimm zero extended
		if (op_i == OP_RWI || op_i == OP_RSI || op_i == OP_RCI) begin
			src = {{(XLEN-5){1'b0}}, zimm_i};
		end else begin
			src = operand_i;
		end

		new_o = old_i;
		we_o  = 1'b0;
		case (op_i)
			OP_RW, OP_RWI: begin
				new_o = src;
				we_o  = 1'b1;
			end
			OP_RS, OP_RSI: begin
				new_o = old_i | src;
				// zero source means read only
				we_o  = |src;
			end
			OP_RC, OP_RCI: begin
				new_o = old_i & ~src;
				we_o  = |src;
			end
			default: begin
				new_o = old_i;
				we_o  = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/reg_csr.sv ====
/*
 * machine mode CSR register file
 * read mux, instruction write port, trap update port and the mcycle counter
 */
`timescale 1ns/1ps
`default_nettype none

module reg_csr
	import csr_pkg::*;
#(
	parameter logic [XLEN-1:0] HART_ID     = '0,
	parameter logic [XLEN-1:0] MTVEC_RESET = 64'h100
) (
	input  logic            clk,
	input  logic            rst_n_i,

	input  logic [11:0]     rd_addr_i,
	output logic [XLEN-1:0] rd_data_o,
	output logic            rd_illegal_o,

	input  csr_wr_t         wr_i,

	input  logic            trap_we_i,
	input  logic [XLEN-1:0] trap_mepc_i,
	input  logic [XLEN-1:0] trap_mcause_i,
	input  logic [XLEN-1:0] trap_mtval_i,
	input  mstatus_u        trap_mstatus_i,

	output mstatus_u        mstatus_o,
	output logic [XLEN-1:0] mtvec_o,
	output logic [XLEN-1:0] mepc_o,
	output logic [XLEN-1:0] mcause_o,
	output logic [XLEN-1:0] mtval_o
);

	mstatus_u        mstatus_q;
	logic [XLEN-1:0] mie_q;
	logic [XLEN-1:0] mtvec_q;
	logic [XLEN-1:0] mscratch_q;
	logic [XLEN-1:0] mepc_q;
	logic [XLEN-1:0] mcause_q;
	logic [XLEN-1:0] mtval_q;
	logic [XLEN-1:0] mcycle_q;

	// per CSR write strobes from the instruction port
	// misa and mhartid have none so their writes drop here
	logic wr_mstatus;
	logic wr_mie;
	logic wr_mtvec;
	logic wr_mscratch;
	logic wr_mepc;
	logic wr_mcause;
	logic wr_mtval;
	logic wr_mcycle;

	assign wr_mstatus  = wr_i.we && (wr_i.addr == CSR_MSTATUS);
	assign wr_mie      = wr_i.we && (wr_i.addr == CSR_MIE);
	assign wr_mtvec    = wr_i.we && (wr_i.addr == CSR_MTVEC);
	assign wr_mscratch = wr_i.we && (wr_i.addr == CSR_MSCRATCH);
	assign wr_mepc     = wr_i.we && (wr_i.addr == CSR_MEPC);
	assign wr_mcause   = wr_i.we && (wr_i.addr == CSR_MCAUSE);
	assign wr_mtval    = wr_i.we && (wr_i.addr == CSR_MTVAL);
	assign wr_mcycle   = wr_i.we && (wr_i.addr == CSR_MCYCLE);

	// trap side CSRs, trap update has priority
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mstatus_q.raw <= MSTATUS_RST;
			mepc_q        <= '0;
			mcause_q      <= '0;
			mtval_q       <= '0;
		end else if (trap_we_i) begin
			mstatus_q.raw <= trap_mstatus_i.raw & MSTATUS_WMASK;
			// pc is at least 4 byte aligned
			mepc_q        <= {trap_mepc_i[XLEN-1:2], 2'b00};
			mcause_q      <= trap_mcause_i;
			mtval_q       <= trap_mtval_i;
		end else begin
			if (wr_mstatus) begin
				mstatus_q.raw <= (mstatus_q.raw & ~MSTATUS_WMASK) |
				                 (wr_i.data & MSTATUS_WMASK);
			end
			if (wr_mepc) begin
				mepc_q <= {wr_i.data[XLEN-1:2], 2'b00};
			end
			if (wr_mcause) begin
				mcause_q <= wr_i.data;
			end
			if (wr_mtval) begin
				mtval_q <= wr_i.data;
			end
		end
	end

	// instruction only CSRs
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mie_q      <= MIE_RST;
			mtvec_q    <= MTVEC_RESET;
			mscratch_q <= '0;
		end else begin
			if (wr_mie) begin
				mie_q <= (mie_q & ~MIE_WMASK) | (wr_i.data & MIE_WMASK);
			end
			// direct mode only
			if (wr_mtvec) begin
				mtvec_q <= {wr_i.data[XLEN-1:2], 2'b00};
			end
			if (wr_mscratch) begin
				mscratch_q <= wr_i.data;
			end
		end
	end

	// free running, a write replaces the increment
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mcycle_q <= '0;
		end else if (wr_mcycle) begin
			mcycle_q <= wr_i.data;
		end else begin
			mcycle_q <= mcycle_q + 64'd1;
		end
	end

	always_comb begin
		rd_illegal_o = 1'b0;
		case (rd_addr_i)
			CSR_MSTATUS:  rd_data_o = mstatus_q.raw;
			CSR_MISA:     rd_data_o = ISA_RV64I;
			CSR_MIE:      rd_data_o = mie_q;
			CSR_MTVEC:    rd_data_o = mtvec_q;
			CSR_MSCRATCH: rd_data_o = mscratch_q;
			CSR_MEPC:     rd_data_o = mepc_q;
			CSR_MCAUSE:   rd_data_o = mcause_q;
			CSR_MTVAL:    rd_data_o = mtval_q;
			CSR_MCYCLE:   rd_data_o = mcycle_q;
			CSR_MHARTID:  rd_data_o = HART_ID;
			default: begin
				// unknown CSR reads zero
				rd_data_o    = '0;
				rd_illegal_o = 1'b1;
			end
		endcase
	end

	assign mstatus_o = mstatus_q;
	assign mtvec_o   = mtvec_q;
	assign mepc_o    = mepc_q;
	assign mcause_o  = mcause_q;
	assign mtval_o   = mtval_q;

endmodule

`default_nettype wire

// ==== hw/csr_access.sv ====
/*
 * csr access front end
 * valid/ready sequencing of one read-modify-write per request, response held under stall
 */
`timescale 1ns/1ps
`default_nettype none

module csr_access
	import csr_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n_i,

	input  logic            req_valid_i,
	input  csr_req_t        req_i,
	output logic            req_ready_o,

	output logic            rsp_valid_o,
	output csr_rsp_t        rsp_o,
	input  logic            rsp_ready_i,

	input  logic            trap_busy_i,

	output logic [11:0]     rd_addr_o,
	input  logic [XLEN-1:0] rd_data_i,
	input  logic            rd_illegal_i,
	output csr_wr_t         wr_o
);

	logic            rsp_valid_q;
	csr_rsp_t        rsp_q;
	logic            accept;
	logic [XLEN-1:0] alu_new;
	logic            alu_we;

	// free slot or slot draining this cycle, trap port wins
	assign req_ready_o = (~rsp_valid_q | rsp_ready_i) & ~trap_busy_i;
	assign accept      = req_valid_i & req_ready_o;

	// old value read combinationally in the accept cycle
	assign rd_addr_o = req_i.addr;

	csr_alu u_csr_alu (
		.op_i      (req_i.op),
		.old_i     (rd_data_i),
		.operand_i (req_i.operand),
		.zimm_i    (req_i.zimm),
		.new_o     (alu_new),
		.we_o      (alu_we)
	);

	// no write for an unknown CSR
	assign wr_o.we   = accept & alu_we & ~rd_illegal_i;
	assign wr_o.addr = req_i.addr;
	assign wr_o.data = alu_new;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rsp_valid_q <= 1'b0;
		end else if (accept) begin
			rsp_valid_q <= 1'b1;
		end else if (rsp_ready_i) begin
			rsp_valid_q <= 1'b0;
		end
	end

	// payload only moves on accept so it holds while stalled
	always_ff @(posedge clk) begin
		if (accept) begin
			rsp_q.rdata   <= rd_data_i;
			rsp_q.illegal <= rd_illegal_i;
		end
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// ==== hw/trap_ctrl.sv ====
/*
 * trap controller
 * exception entry and mret as a CSR update plus a one cycle fetch redirect
 */
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl
	import csr_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n_i,

	input  logic            trap_valid_i,
	input  trap_req_t       trap_i,

	input  mstatus_u        mstatus_i,
	input  logic [XLEN-1:0] mtvec_i,
	input  logic [XLEN-1:0] mepc_i,
	input  logic [XLEN-1:0] mcause_i,
	input  logic [XLEN-1:0] mtval_i,

	output logic            trap_we_o,
	output logic [XLEN-1:0] trap_mepc_o,
	output logic [XLEN-1:0] trap_mcause_o,
	output logic [XLEN-1:0] trap_mtval_o,
	output mstatus_u        trap_mstatus_o,

	output redirect_t       redirect_o
);

	logic            redir_valid_q;
	logic [XLEN-1:0] redir_pc_q;

	assign trap_we_o = trap_valid_i;

	always_comb begin
		trap_mstatus_o = mstatus_i;
		if (trap_i.kind == TRAP_MRET) begin
			// restore interrupt enable
			trap_mstatus_o.f.mie  = mstatus_i.f.mpie;
			trap_mstatus_o.f.mpie = 1'b1;
			// mret leaves these as they are
			trap_mepc_o   = mepc_i;
			trap_mcause_o = mcause_i;
			trap_mtval_o  = mtval_i;
		end else begin
			// stack MIE and mask interrupts
			trap_mstatus_o.f.mpie = mstatus_i.f.mie;
			trap_mstatus_o.f.mie  = 1'b0;
			trap_mepc_o   = trap_i.pc;
			trap_mcause_o = trap_i.cause;
			trap_mtval_o  = trap_i.tval;
		end
	end

	// valid for the single cycle after the trap edge
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			redir_valid_q <= 1'b0;
		end else begin
			redir_valid_q <= trap_valid_i;
		end
	end

	// target sampled before the CSR update lands
	always_ff @(posedge clk) begin
		if (trap_valid_i) begin
			redir_pc_q <= (trap_i.kind == TRAP_MRET) ? mepc_i : mtvec_i;
		end
	end

	assign redirect_o.valid = redir_valid_q;
	assign redirect_o.pc    = redir_pc_q;

endmodule

`default_nettype wire

// ==== hw/csr_unit_top.sv ====
/*
 * machine mode CSR unit
 * request/response CSR access and trap port around one CSR register file
 */
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top
	import csr_pkg::*;
#(
	parameter logic [XLEN-1:0] HART_ID     = '0,
	parameter logic [XLEN-1:0] MTVEC_RESET = 64'h100
) (
	input  logic      clk,
	input  logic      rst_n_i,

	input  logic      req_valid_i,
	input  csr_req_t  req_i,
	output logic      req_ready_o,

	output logic      rsp_valid_o,
	output csr_rsp_t  rsp_o,
	input  logic      rsp_ready_i,

	input  logic      trap_valid_i,
	input  trap_req_t trap_i,
	output redirect_t redirect_o
);

	logic [11:0]     rd_addr;
	logic [XLEN-1:0] rd_data;
	logic            rd_illegal;
	csr_wr_t         csr_wr;

	logic            trap_we;
	logic [XLEN-1:0] trap_mepc;
	logic [XLEN-1:0] trap_mcause;
	logic [XLEN-1:0] trap_mtval;
	mstatus_u        trap_mstatus;

	mstatus_u        mstatus;
	logic [XLEN-1:0] mtvec;
	logic [XLEN-1:0] mepc;
	logic [XLEN-1:0] mcause;
	logic [XLEN-1:0] mtval;

	// a pending trap blocks new requests
	csr_access u_csr_access (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.req_ready_o  (req_ready_o),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_o        (rsp_o),
		.rsp_ready_i  (rsp_ready_i),
		.trap_busy_i  (trap_valid_i),
		.rd_addr_o    (rd_addr),
		.rd_data_i    (rd_data),
		.rd_illegal_i (rd_illegal),
		.wr_o         (csr_wr)
	);

	trap_ctrl u_trap_ctrl (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.trap_valid_i   (trap_valid_i),
		.trap_i         (trap_i),
		.mstatus_i      (mstatus),
		.mtvec_i        (mtvec),
		.mepc_i         (mepc),
		.mcause_i       (mcause),
		.mtval_i        (mtval),
		.trap_we_o      (trap_we),
		.trap_mepc_o    (trap_mepc),
		.trap_mcause_o  (trap_mcause),
		.trap_mtval_o   (trap_mtval),
		.trap_mstatus_o (trap_mstatus),
		.redirect_o     (redirect_o)
	);

	reg_csr #(
		.HART_ID     (HART_ID),
		.MTVEC_RESET (MTVEC_RESET)
	) u_reg_csr (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.rd_addr_i      (rd_addr),
		.rd_data_o      (rd_data),
		.rd_illegal_o   (rd_illegal),
		.wr_i           (csr_wr),
		.trap_we_i      (trap_we),
		.trap_mepc_i    (trap_mepc),
		.trap_mcause_i  (trap_mcause),
		.trap_mtval_i   (trap_mtval),
		.trap_mstatus_i (trap_mstatus),
		.mstatus_o      (mstatus),
		.mtvec_o        (mtvec),
		.mepc_o         (mepc),
		.mcause_o       (mcause),
		.mtval_o        (mtval)
	);

endmodule

`default_nettype wire

// ==== dv/tb_csr_unit.sv ====
/*
 * testbench for the machine mode CSR unit
 * replays csr, trap and mcycle lines from a stimulus file and checks every result
 */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit
	import csr_pkg::*;
();

	// line kinds as %s leaves them right aligned
	localparam logic [63:0] TAG_NOTE = {56'd0, "#"};
	localparam logic [63:0] TAG_CSR  = {40'd0, "csr"};
	localparam logic [63:0] TAG_TRAP = {32'd0, "trap"};
	localparam logic [63:0] TAG_CYC  = {40'd0, "cyc"};

	logic      clk;
	logic      rst_n_i;
	logic      req_valid_i;
	csr_req_t  req_i;
	logic      req_ready_o;
	logic      rsp_valid_o;
	csr_rsp_t  rsp_o;
	logic      rsp_ready_i;
	logic      trap_valid_i;
	trap_req_t trap_i;
	redirect_t redirect_o;

	longint unsigned edge_cnt;
	longint unsigned last_acc_edge;
	logic [31:0]     lcg_state;

	csr_unit_top #(
		.HART_ID     (64'd3),
		.MTVEC_RESET (64'h100)
	) dut_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.req_ready_o  (req_ready_o),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_o        (rsp_o),
		.rsp_ready_i  (rsp_ready_i),
		.trap_valid_i (trap_valid_i),
		.trap_i       (trap_i),
		.redirect_o   (redirect_o)
	);

	always #2 clk = ~clk;

	// rising edges so far
	// read only between edges
	always @(posedge clk) begin
		edge_cnt <= edge_cnt + 64'd1;
	end

	// lcg step
	// two middle bits give 0 to 3 stall cycles
	function automatic logic [1:0] next_stall();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[17:16];
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_rsp(input csr_rsp_t exp, input csr_rsp_t act);
		if (act !== exp) begin
			abort_run($sformatf("error: t=%0t rsp_o expected %h actual %h",
				$time, exp, act));
		end
	endtask

	task automatic check_redirect(input redirect_t exp, input redirect_t act);
		if (act !== exp) begin
			abort_run($sformatf("error: t=%0t redirect_o expected %h actual %h",
				$time, exp, act));
		end
	endtask

	// records the edge count seen just before the acceptance edge
	task automatic send_req(input csr_req_t req);
		int n;
		n = 0;
		@(negedge clk);
		req_i       = req;
		req_valid_i = 1'b1;
		// ready is combinational on rsp_ready_i
		#1;
		while (!req_ready_o) begin
			if (n == 100) begin
				abort_run("request was never accepted");
			end
			n++;
			@(negedge clk);
			#1;
		end
		last_acc_edge = edge_cnt;
		@(negedge clk);
		req_valid_i = 1'b0;
	endtask

	task automatic take_rsp(output csr_rsp_t rsp);
		int         n;
		logic [1:0] stall;
		n = 0;
		while (!rsp_valid_o) begin
			if (n == 100) begin
				abort_run("response valid never arrived");
			end
			n++;
			@(negedge clk);
		end
		// random back-pressure before the transfer
		stall = next_stall();
		repeat (stall) @(negedge clk);
		if (!rsp_valid_o) begin
			abort_run("response valid dropped while stalled");
		end
		// a held response blocks the request channel
		if (req_ready_o) begin
			abort_run("request channel was ready while a response was held");
		end
		rsp_ready_i = 1'b1;
		rsp         = rsp_o;
		// a draining response frees the slot in the same cycle
		#1;
		if (!req_ready_o) begin
			abort_run("request channel was not ready while the response drained");
		end
		@(negedge clk);
		rsp_ready_i = 1'b0;
		if (rsp_valid_o) begin
			abort_run("response was repeated after its transfer");
		end
	endtask

	task automatic exec_csr(input csr_req_t req, input csr_rsp_t exp);
		csr_rsp_t rsp;
		send_req(req);
		take_rsp(rsp);
		check_rsp(exp, rsp);
	endtask

	task automatic apply_trap(input trap_req_t trap, input logic [XLEN-1:0] target);
		int        n;
		redirect_t exp;
		n         = 0;
		exp.valid = 1'b1;
		exp.pc    = target;
		@(negedge clk);
		trap_i       = trap;
		trap_valid_i = 1'b1;
		@(negedge clk);
		trap_valid_i = 1'b0;
		while (!redirect_o.valid) begin
			if (n == 100) begin
				abort_run("redirect never arrived after the trap");
			end
			n++;
			@(negedge clk);
		end
		check_redirect(exp, redirect_o);
		@(negedge clk);
		if (redirect_o.valid) begin
			abort_run("redirect stayed valid for more than one cycle");
		end
	endtask

	// write mcycle then read it twice
	task automatic measure_mcycle(input logic [XLEN-1:0] wval);
		longint unsigned e0;
		longint unsigned e1;
		longint unsigned e2;
		csr_rsp_t        r0;
		csr_rsp_t        r1;
		csr_rsp_t        r2;
		csr_rsp_t        exp;
		csr_req_t        req;
		req.op      = OP_RW;
		req.addr    = CSR_MCYCLE;
		req.operand = wval;
		req.zimm    = '0;
		send_req(req);
		e0 = last_acc_edge;
		take_rsp(r0);
		if (r0.illegal) begin
			abort_run("mcycle write was flagged illegal");
		end
		req.op      = OP_RS;
		req.operand = '0;
		send_req(req);
		e1 = last_acc_edge;
		take_rsp(r1);
		send_req(req);
		e2 = last_acc_edge;
		take_rsp(r2);
		if (r1.rdata <= wval || r2.rdata <= wval) begin
			abort_run("mcycle did not count past the written value");
		end
		// the write edge loads wval and each later edge adds one
		exp.rdata   = wval + (e1 - e0) - 64'd1;
		exp.illegal = 1'b0;
		check_rsp(exp, r1);
		exp.rdata   = exp.rdata + (e2 - e1);
		check_rsp(exp, r2);
	endtask

	initial begin
		int                r;
		int                fd;
		int                n_lines;
		logic [63:0]       tag;
		logic [8*160-1:0]  skip;
		logic [2:0]        op_v;
		logic [11:0]       addr_v;
		logic [XLEN-1:0]   a_v;
		logic [XLEN-1:0]   b_v;
		logic [XLEN-1:0]   c_v;
		logic [XLEN-1:0]   d_v;
		logic [4:0]        zimm_v;
		logic              bit_v;
		csr_req_t          req;
		csr_rsp_t          exp;
		trap_req_t         trap;
		clk           = 1'b0;
		rst_n_i       = 1'b0;
		req_valid_i   = 1'b0;
		req_i         = '0;
		rsp_ready_i   = 1'b0;
		trap_valid_i  = 1'b0;
		trap_i        = '0;
		edge_cnt      = 0;
		last_acc_edge = 0;
		lcg_state     = 32'd19;
		n_lines       = 0;
		fd = $fopen("dv/csr_stim.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open dv/csr_stim.txt");
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		#1;
		if (!req_ready_o || rsp_valid_o || redirect_o.valid) begin
			abort_run("handshake outputs not idle after reset");
		end
		while (!$feof(fd)) begin
			tag = '0;
			r   = $fscanf(fd, "%s", tag);
			if (r != 1) begin
				break;
			end
			if (tag == TAG_NOTE) begin
				r = $fgets(skip, fd);
			end else if (tag == TAG_CSR) begin
				r = $fscanf(fd, "%h %h %h %h %h %h", op_v, addr_v, a_v, zimm_v, b_v, bit_v);
				if (r != 6) begin
					abort_run("malformed csr line in stimulus file");
				end
				req.op      = csr_op_e'(op_v);
				req.addr    = addr_v;
				req.operand = a_v;
				req.zimm    = zimm_v;
				exp.rdata   = b_v;
				exp.illegal = bit_v;
				exec_csr(req, exp);
				n_lines++;
			end else if (tag == TAG_TRAP) begin
				r = $fscanf(fd, "%h %h %h %h %h", bit_v, a_v, b_v, c_v, d_v);
				if (r != 5) begin
					abort_run("malformed trap line in stimulus file");
				end
				trap.kind  = trap_kind_e'(bit_v);
				trap.pc    = a_v;
				trap.cause = b_v;
				trap.tval  = c_v;
				apply_trap(trap, d_v);
				n_lines++;
			end else if (tag == TAG_CYC) begin
				r = $fscanf(fd, "%h", a_v);
				if (r != 1) begin
					abort_run("malformed cyc line in stimulus file");
				end
				measure_mcycle(a_v);
				n_lines++;
			end else begin
				abort_run("unknown line kind in stimulus file");
			end
		end
		$fclose(fd);
		if (n_lines < 10) begin
			abort_run("stimulus file held too few lines");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== dv/csr_stim.txt ====
# csr op addr operand zimm old_value illegal (op 1 rw 2 rs 3 rc 5 rwi 6 rsi 7 rci)
# trap kind pc cause tval redirect_target (kind 0 exception 1 mret) and cyc mcycle_write
csr 2 300 0 0 8 0
csr 2 301 0 0 8000000000000100 0
csr 2 304 0 0 888 0
csr 2 305 0 0 100 0
csr 2 340 0 0 0 0
csr 2 341 0 0 0 0
csr 2 342 0 0 0 0
csr 2 343 0 0 0 0
csr 2 f14 0 0 3 0
csr 1 340 123456789abcdef0 0 0 0
csr 2 340 ff 0 123456789abcdef0 0
csr 3 340 f000000000000000 0 123456789abcdeff 0
csr 5 340 0 1f 023456789abcdeff 0
csr 6 340 0 0 1f 0
csr 7 340 0 3 1f 0
csr 3 340 0 0 1c 0
csr 1 305 2003 0 100 0
csr 1 300 ffffffffffffffff 0 8 0
csr 7 300 0 8 88 0
csr 5 300 0 f 80 0
csr 1 304 f0 0 888 0
csr 2 304 0 0 80 0
csr 1 301 0 0 8000000000000100 0
csr 1 f14 ffff 0 3 0
csr 1 7c0 dead 0 0 1
csr 2 7c0 0 0 0 1
csr 2 301 0 0 8000000000000100 0
csr 2 f14 0 0 3 0
trap 0 80000006 2 deadbeef 2000
csr 2 341 0 0 80000004 0
csr 2 342 0 0 2 0
csr 2 343 0 0 deadbeef 0
csr 2 300 0 0 80 0
trap 1 0 0 0 80000004
csr 2 300 0 0 88 0
csr 2 341 0 0 80000004 0
cyc 1000
csr 2 340 0 0 1c 0
csr 2 305 0 0 2000 0

// ==== tb.f ====
hw/csr_pkg.sv
hw/csr_alu.sv
hw/reg_csr.sv
hw/csr_access.sv
hw/trap_ctrl.sv
hw/csr_unit_top.sv
dv/tb_csr_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the CSR unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f tb.f --top-module tb_csr_unit -o tb_csr_unit

# the stimulus path is relative to the project root
./obj_dir/tb_csr_unit | tee sim.log

if grep -q "PASS: all tests" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
